/* resize.f */
verilog/resize_pkg.sv
verilog/patch_if.sv
verilog/weighted_if.sv
verilog/patch_phase_tracker.sv
verilog/bilinear_weighter.sv
verilog/bilinear_summer.sv
verilog/resize_top.sv
verif/resize_chk.sv
verif/resize_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the downscaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module resize_tb -f resize.f -o resize_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/resize_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* verif/resize_chk.sv */
module resize_chk
    import resize_pkg::*;
(
    input logic   i_clk,
    input logic   i_rst,
    input logic   i_in_valid,
    input logic   i_line_start,
    input logic   i_patch_valid,
    input phase_t i_u,
    input phase_t i_v,
    input phase_t i_patch_u,
    input phase_t i_patch_v
);

    localparam phase_t PH_LAST = phase_t'(PHASE_MAX);

    // a whole step is never passed on
    keep_phase_a: assert property (@(posedge i_clk) disable iff (i_rst)
        i_patch_valid |-> (i_patch_u != PH_LAST && i_patch_v != PH_LAST))
        else $error("kept patch with a phase at a whole step");

    // quarter steps only
    phase_range_a: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_u <= PH_LAST && i_v <= PH_LAST))
        else $error("phase counter above a whole step");

    // first patch of a line starts at u 0
    line_start_a: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_in_valid && i_line_start) |-> (i_u == phase_t'(0)))
        else $error("u not zero at line start");

endmodule

bind patch_phase_tracker resize_chk u_chk (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_in_valid    (in_valid),
    .i_line_start  (col_cnt == '0),
    .i_patch_valid (o_patch.valid),
    .i_u           (u_cnt),
    .i_v           (v_cnt),
    .i_patch_u     (o_patch.u),
    .i_patch_v     (o_patch.v)
);

/* verif/resize_tb.sv */
module resize_tb;

    ////////////////////////////////////////////////////////////
    // run lengths, all in clock cycles
    ////////////////////////////////////////////////////////////

    localparam int SRC_PATCH_W = 12;
    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYC     = 10;
    localparam int IDLE_CYC    = 20;
    localparam int DIR_CYC     = 36;
    localparam int RAND_CYC    = 300;
    localparam int TAIL_CYC    = 10;
    // patches driven just before the mid-run reset
    localparam int MID_CYC     = 2;
    // eight registers from input pins to output pins
    localparam int LATENCY     = 8;
    localparam int STIM_CYC    = 2 * (RST_CYC + 1) + IDLE_CYC + DIR_CYC + 2 * RAND_CYC
                               + MID_CYC + 3 * (LATENCY + TAIL_CYC);
    // one whole source step in quarter units
    localparam int STEP        = 4;

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic [31:0] i_data;
    logic        i_data_valid;
    logic [7:0]  o_data;
    logic        o_data_valid;

    // rising edges seen so far
    int          cyc = 0;
    logic [31:0] lfsr_state = 32'he422_d788;

    // model state
    int          col;
    int          line;
    int          kept_cnt;
    int          out_cnt;
    int          exp_pix_q[$];
    int          exp_cyc_q[$];

    resize_top #(
        .SRC_PATCH_W (SRC_PATCH_W)
    ) i_dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_data       (i_data),
        .i_data_valid (i_data_valid),
        .o_data       (o_data),
        .o_data_valid (o_data_valid)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////////////////////////
    // error reporting and compare
    ////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        string msg;
        if (exp !== act) begin
            msg = $sformatf("Fail %s expected %0h actual %0h", name, exp, act);
            stop_with_error(msg);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////

    // galois form, shifts right, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // q11 low byte, then q21, q12, q22
    function automatic int bilinear_pixel(input logic [31:0] w, input int u, input int v);
        int q11;
        int q21;
        int q12;
        int q22;
        int acc;
        q11 = int'(w[7:0]);
        q21 = int'(w[15:8]);
        q12 = int'(w[23:16]);
        q22 = int'(w[31:24]);
        acc = q11 * (STEP - u) * (STEP - v) + q21 * (STEP - u) * v
            + q12 * u * (STEP - v) + q22 * u * v;
        return acc >> 4;
    endfunction

    // called in the cycle the patch is driven
    task automatic accept_patch(input logic [31:0] w);
        int u;
        int v;
        u = col % 5;
        v = line % 5;
        // u or v at a whole step is dropped
        if (u != STEP && v != STEP) begin
            exp_pix_q.push_back(bilinear_pixel(w, u, v));
            exp_cyc_q.push_back(cyc + LATENCY);
            kept_cnt++;
        end
        col++;
        if (col == SRC_PATCH_W) begin
            col = 0;
            line++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers, all on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic drive_slot(input logic valid, input logic [31:0] data);
        @(negedge i_clk);
        i_data_valid = valid;
        i_data       = data;
        if (valid) begin
            accept_patch(data);
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_data_valid = 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst        = 1'b1;
        i_data_valid = 1'b0;
        // phases restart from zero
        col          = 0;
        line         = 0;
        repeat (RST_CYC) @(negedge i_clk);
        i_rst = 1'b0;
    endtask

    // random patches, idle stretches come out of the same budget
    task automatic drive_random(input int budget);
        logic [31:0] gap;
        logic [31:0] bits;
        logic [31:0] data;
        int          left;
        int          idle_len;
        left = budget;
        while (left > 0) begin
            draw_bits(4, gap);
            if (gap[3:0] == 4'd0) begin
                draw_bits(3, bits);
                idle_len = int'(bits[2:0]) + 1;
                if (idle_len > left) begin
                    idle_len = left;
                end
                drive_idle(idle_len);
                left -= idle_len;
            end else begin
                // valid high about three times in four
                draw_bits(2, bits);
                draw_bits(32, data);
                drive_slot(bits[1:0] != 2'b00, data);
                left--;
            end
        end
    endtask

    // let everything in flight come out, then watch for strays
    task automatic drain_outputs();
        drive_idle(LATENCY + TAIL_CYC);
        check_value("output count", kept_cnt, out_cnt);
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (o_data_valid === 1'b1) begin
            if (exp_pix_q.size() == 0) begin
                stop_with_error("output strobe seen with no kept patch pending");
            end else begin
                check_value("o_data", exp_pix_q.pop_front(), 32'(o_data));
                check_value("o_data_valid cycle", exp_cyc_q.pop_front(), cyc);
                out_cnt++;
            end
        end
    end

    // limit worked out from the stimulus length
    initial begin
        #((STIM_CYC + 20) * CLK_PERIOD);
        stop_with_error("watchdog timeout, the run did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        i_rst        = 1'b1;
        i_data       = '0;
        i_data_valid = 1'b0;
        col          = 0;
        line         = 0;
        kept_cnt     = 0;
        out_cnt      = 0;
        apply_reset();
        // nothing in, nothing out
        drive_idle(IDLE_CYC);
        // two full-white lines then a black one, back to back
        repeat (2 * SRC_PATCH_W) drive_slot(1'b1, 32'hFFFF_FFFF);
        repeat (SRC_PATCH_W) drive_slot(1'b1, 32'h0000_0000);
        drive_random(RAND_CYC);
        drain_outputs();
        // reset part way into a line
        drive_slot(1'b1, 32'h1234_5678);
        drive_slot(1'b1, 32'h9ABC_DEF0);
        drain_outputs();
        apply_reset();
        drive_random(RAND_CYC);
        drain_outputs();
        if (exp_pix_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_error("kept patches still pending at the end of the run");
        end
    end

endmodule

/* verilog/bilinear_summer.sv */
module bilinear_summer
    import resize_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    weighted_if.dst  i_terms,
    output pixel_t   o_data,
    output logic     o_data_valid
);

    sum_t sum_top;
    sum_t sum_bot;
    sum_t sum_all;
    logic sum_valid;

    ////////////////////////////////////////////////////////////
    // adder level 1
    ////////////////////////////////////////////////////////////

    // q11/q21 terms and q12/q22 terms
    always_ff @(posedge i_clk) begin
        sum_top <= sum_t'(i_terms.t11) + sum_t'(i_terms.t21);
        sum_bot <= sum_t'(i_terms.t12) + sum_t'(i_terms.t22);
    end

    ////////////////////////////////////////////////////////////
    // adder level 2 and normalise
    ////////////////////////////////////////////////////////////

    assign sum_all = sum_top + sum_bot;

    // divide by 16, result never exceeds 255
    always_ff @(posedge i_clk) begin
        o_data <= sum_all[SUM_SHIFT +: PIX_W];
    end

    // strobe alignment
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sum_valid    <= 1'b0;
            o_data_valid <= 1'b0;
        end else begin
            sum_valid    <= i_terms.valid;
            o_data_valid <= sum_valid;
        end
    end

endmodule

/* verilog/bilinear_weighter.sv */
module bilinear_weighter
    import resize_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    patch_if.dst    i_patch,
    weighted_if.src o_terms
);

    localparam int LANES = 4;

    // lanes in order q11, q21, q12, q22
    pixel_t     lane_pix [LANES];
    phase_t     lane_wh  [LANES];
    phase_t     lane_wv  [LANES];
    prod1_t     s1_prod  [LANES];
    prod1_t     s1_dly   [LANES];
    prod2_t     s2_prod  [LANES];
    phase_t     s1_v;
    phase_t     s1_v_inv;
    phase_t     s1d_v;
    phase_t     s1d_v_inv;
    logic [2:0] vld_sr;

    ////////////////////////////////////////////////////////////
    // lane operands
    ////////////////////////////////////////////////////////////

    always_comb begin
        lane_pix[0] = i_patch.pixels.pix.q11;
        lane_pix[1] = i_patch.pixels.pix.q21;
        lane_pix[2] = i_patch.pixels.pix.q12;
        lane_pix[3] = i_patch.pixels.pix.q22;
        // horizontal weight, q11/q21 take 4-u
        lane_wh[0]  = i_patch.u_inv;
        lane_wh[1]  = i_patch.u_inv;
        lane_wh[2]  = i_patch.u;
        lane_wh[3]  = i_patch.u;
        // vertical weight, q11/q12 take 4-v
        lane_wv[0]  = s1d_v_inv;
        lane_wv[1]  = s1d_v;
        lane_wv[2]  = s1d_v_inv;
        lane_wv[3]  = s1d_v;
    end

    ////////////////////////////////////////////////////////////
    // stage 1 then stage 2, two registers each
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < LANES; i++) begin
            s1_prod[i] <= prod1_t'(lane_pix[i]) * prod1_t'(lane_wh[i]);
            s1_dly[i]  <= s1_prod[i];
            s2_prod[i] <= prod2_t'(s1_dly[i]) * prod2_t'(lane_wv[i]);
        end
        // v rides along with the stage-1 products
        s1_v      <= i_patch.v;
        s1_v_inv  <= i_patch.v_inv;
        s1d_v     <= s1_v;
        s1d_v_inv <= s1_v_inv;
        // second stage-2 register is the interface itself
        o_terms.t11 <= s2_prod[0];
        o_terms.t21 <= s2_prod[1];
        o_terms.t12 <= s2_prod[2];
        o_terms.t22 <= s2_prod[3];
    end

    // strobe follows the data through all four registers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_sr        <= '0;
            o_terms.valid <= 1'b0;
        end else begin
            vld_sr        <= {vld_sr[1:0], i_patch.valid};
            o_terms.valid <= vld_sr[2];
        end
    end

endmodule

/* verilog/patch_if.sv */
interface patch_if
    import resize_pkg::*;
();

    // one-cycle strobe, kept patches only
    logic        valid;

    // patch as registered from the input bus
    patch_word_u pixels;

    // horizontal phase and its complement
    phase_t      u;
    phase_t      u_inv;

    // vertical phase and its complement
    phase_t      v;
    phase_t      v_inv;

    // tracker side
    modport src (output valid, pixels, u, u_inv, v, v_inv);

    // weighter side
    modport dst (input valid, pixels, u, u_inv, v, v_inv);

endinterface

/* verilog/patch_phase_tracker.sv */
module patch_phase_tracker
    import resize_pkg::*;
#(
    parameter int SRC_PATCH_W = 640
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [31:0] i_data,
    input  logic        i_data_valid,
    patch_if.src        o_patch
);

    localparam int COL_W = $clog2(SRC_PATCH_W + 1);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(SRC_PATCH_W - 1);
    localparam phase_t PH_LAST = phase_t'(PHASE_MAX);

    patch_word_u      in_word;
    logic             in_valid;
    logic [COL_W-1:0] col_cnt;
    phase_t           u_cnt;
    phase_t           v_cnt;
    logic             line_end;
    logic             keep;

    ////////////////////////////////////////////////////////////
    // input register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= i_data_valid;
        end
    end

    // payload, no reset
    always_ff @(posedge i_clk) begin
        in_word.raw <= i_data;
    end

    ////////////////////////////////////////////////////////////
    // column / line phase counting
    ////////////////////////////////////////////////////////////

    // last patch of the source line
    assign line_end = (col_cnt == COL_LAST);

    // u=4 or v=4 falls on the next source pixel, drop it
    assign keep = in_valid && (u_cnt != PH_LAST) && (v_cnt != PH_LAST);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            u_cnt   <= '0;
            v_cnt   <= '0;
        end else if (in_valid) begin
            if (line_end) begin
                // new line, u restarts even if width is not a multiple of 5
                col_cnt <= '0;
                u_cnt   <= '0;
                v_cnt   <= (v_cnt == PH_LAST) ? phase_t'(0) : v_cnt + phase_t'(1);
            end else begin
                col_cnt <= col_cnt + COL_W'(1);
                u_cnt   <= (u_cnt == PH_LAST) ? phase_t'(0) : u_cnt + phase_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // decision register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_patch.valid <= 1'b0;
        end else begin
            o_patch.valid <= keep;
        end
    end

    // phases of the current patch, not the updated counters
    always_ff @(posedge i_clk) begin
        if (in_valid) begin
            o_patch.pixels <= in_word;
            o_patch.u      <= u_cnt;
            o_patch.u_inv  <= PH_LAST - u_cnt;
            o_patch.v      <= v_cnt;
            o_patch.v_inv  <= PH_LAST - v_cnt;
        end
    end

endmodule

/* verilog/resize_pkg.sv */
package resize_pkg;

    ////////////////////////////////////////////////////////////
    // pixel and phase widths
    ////////////////////////////////////////////////////////////

    localparam int PIX_W = 8;
    typedef logic [PIX_W-1:0] pixel_t;

    // one whole source step, phases count in quarters
    localparam int PHASE_MAX = 4;
    localparam int PHASE_W   = 3;

    // also used for the 4-x weights
    typedef logic [PHASE_W-1:0] phase_t;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    // pixel x weight, max 255*4
    typedef logic [10:0] prod1_t;
    // second weight applied, max 255*16
    typedef logic [11:0] prod2_t;
    // room for the two adder levels
    typedef logic [13:0] sum_t;

    // the four weights always add up to 16
    localparam int SUM_SHIFT = 4;

    ////////////////////////////////////////////////////////////
    // input patch word
    ////////////////////////////////////////////////////////////

    // 2x2 patch, q11 in the low byte
    typedef struct packed {
        pixel_t q22;
        pixel_t q12;
        pixel_t q21;
        pixel_t q11;
    } patch_pixels_t;

    // raw bus view or per-pixel view of the same word
    typedef union packed {
        logic [4*PIX_W-1:0] raw;
        patch_pixels_t      pix;
    } patch_word_u;

endpackage

/* verilog/resize_top.sv */
module resize_top
    import resize_pkg::*;
#(
    // patches per source line
    parameter int SRC_PATCH_W = 640
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [31:0] i_data,
    input  logic        i_data_valid,
    output pixel_t      o_data,
    output logic        o_data_valid
);

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////

    patch_if    patch_bus ();
    weighted_if term_bus ();

    ////////////////////////////////////////////////////////////
    // pipeline, 2 + 4 + 2 cycles
    ////////////////////////////////////////////////////////////

    // phase tracking and 5-to-4 decimation
    patch_phase_tracker #(
        .SRC_PATCH_W (SRC_PATCH_W)
    ) u_tracker (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_data       (i_data),
        .i_data_valid (i_data_valid),
        .o_patch      (patch_bus.src)
    );

    // horizontal then vertical weights
    bilinear_weighter u_weighter (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_patch (patch_bus.dst),
        .o_terms (term_bus.src)
    );

    // adder tree and output register
    bilinear_summer u_summer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_terms      (term_bus.dst),
        .o_data       (o_data),
        .o_data_valid (o_data_valid)
    );

endmodule

/* verilog/weighted_if.sv */
interface weighted_if
    import resize_pkg::*;
();

    // one-cycle strobe, same rule as patch_if
    logic   valid;

    // q11*(4-u)*(4-v) and q21*(4-u)*v
    prod2_t t11;
    prod2_t t21;

    // q12*u*(4-v) and q22*u*v
    prod2_t t12;
    prod2_t t22;

    // weighter side
    modport src (output valid, t11, t21, t12, t22);

    // summer side
    modport dst (input valid, t11, t21, t12, t22);

endinterface
